/* common/cmdPkg.sv */
package cmdPkg;

	// ------------------------------------------------
	// Frame field widths
	// ------------------------------------------------

	// Short frame is {cmd, addr, val}
	localparam int CMD_W  = 4;
	localparam int ADDR_W = 4;
	localparam int VAL_W  = 8;

	// Frame lengths in SCK bits
	localparam int SHORT_BITS = 16;
	localparam int LONG_BITS  = 40;

	// Address field carried by the long frame
	localparam int REQ_ADDR_W = 10;

	// ------------------------------------------------
	// Command codes and constants
	// ------------------------------------------------

	typedef enum logic [CMD_W-1:0] {
		setRegs = 4'h2,
		getRegs = 4'h3,
		sendId  = 4'h6,
		longMsg = 4'h9
	} cmd_e;

	// Op byte at the top of the long frame
	localparam logic [7:0] RAM_OP_WRITE = 8'h01;
	localparam logic [7:0] RAM_OP_READ  = 8'h02;

	// Test register values after reset
	localparam logic [VAL_W-1:0] REG0_RESET = 8'h12;
	localparam logic [VAL_W-1:0] REG1_RESET = 8'h34;

	// Identity reply
	localparam logic [SHORT_BITS-1:0] DEVICE_ID = 16'h7975;

	// ------------------------------------------------
	// Shared types
	// ------------------------------------------------

	// Command word, field view
	typedef struct packed {
		logic [CMD_W-1:0]  cmd;
		logic [ADDR_W-1:0] addr;
		logic [VAL_W-1:0]  val;
	} cmdFields_t;

	// Same 16 bits, decoded as fields or taken as a data word
	typedef union packed {
		cmdFields_t            fields;
		logic [SHORT_BITS-1:0] raw;
	} cmdWord_u;

	// Long frame, MSB first on the wire
	typedef struct packed {
		logic [7:0]            op;
		logic [5:0]            unused;
		logic [REQ_ADDR_W-1:0] addr;
		logic [SHORT_BITS-1:0] data;
	} ramReq_t;

	// RAM request, sequencer to buffer
	typedef struct packed {
		logic                  we;
		logic [REQ_ADDR_W-1:0] addr;
		logic [SHORT_BITS-1:0] din;
	} ramCtl_t;

	// Reply source
	typedef enum logic [1:0] {
		replyRegs,
		replyId,
		replyRam
	} replySel_e;

endpackage

/* dv/cmdDecoderTb.sv */
`timescale 1ns/1ns

module cmdDecoderTb;

	// Table size limit
	localparam int MAX_ROWS = 40;

	// DUT pins
	logic CLK = 1'b0;
	logic CMD_RST;
	logic SCK;
	logic MOSI;
	logic CSEL;
	logic MISO;

	// ------------------------------------------------
	// Stimulus table
	// ------------------------------------------------

	string       rowName   [MAX_ROWS];
	int          rowWidth  [MAX_ROWS];
	logic [39:0] rowWord   [MAX_ROWS];
	logic [15:0] rowExpect [MAX_ROWS];
	bit          rowCheck  [MAX_ROWS];
	int          numRows;

	// Reference state kept from the command rules
	logic [7:0]  reg0Model;
	logic [7:0]  reg1Model;
	logic [15:0] ramModel [1024];
	logic [9:0]  pairAddr [4];

	// Fixed seed for the RAM pairs
	int seed;

	// Run bookkeeping
	int          errorCount;
	int          passCount;
	int          cycleCount;
	int          timeoutLimit = 0;
	int          rowIdx;
	logic [15:0] reply;

	cmdDecoderTop i_cmdDecoderTop (
		.CLK     (CLK),
		.CMD_RST (CMD_RST),
		.SCK     (SCK),
		.MOSI    (MOSI),
		.CSEL    (CSEL),
		.MISO    (MISO)
	);

	// 8 ns period
	always #4 CLK = ~CLK;

	// ------------------------------------------------
	// Frame encoders
	// ------------------------------------------------

	// Short frame in the low 16 bits
	function automatic logic [39:0] shortCmd(input logic [3:0] cmd, input logic [3:0] addr,
			input logic [7:0] val);
		shortCmd = {24'h0, cmd, addr, val};
	endfunction

	// Long request {op, 6 spare, addr, data}
	function automatic logic [39:0] longReq(input logic [7:0] op, input logic [9:0] addr,
			input logic [15:0] data);
		longReq = {op, 6'h0, addr, data};
	endfunction

	// ------------------------------------------------
	// Table building
	// ------------------------------------------------

	task automatic addRow(input string name, input int width, input logic [39:0] word,
			input logic [15:0] expValue, input bit check);
		rowName[numRows]   = name;
		rowWidth[numRows]  = width;
		rowWord[numRows]   = word;
		rowExpect[numRows] = expValue;
		rowCheck[numRows]  = check;
		numRows = numRows + 1;
	endtask

	// Register read reply is {3, addr, value or 00}
	task automatic addRegRead(input string name, input logic [3:0] addr);
		logic [7:0] val;
		val = 8'h00;
		if (addr == 4'd1) begin
			val = reg0Model;
		end
		if (addr == 4'd2) begin
			val = reg1Model;
		end
		addRow(name, 16, shortCmd(4'h3, addr, 8'h00), {4'h3, addr, val}, 1'b1);
	endtask

	// Header frame, then the 40-bit request
	task automatic addRamRead(input string name, input logic [9:0] addr);
		addRow({name, "Hdr"}, 16, shortCmd(4'h9, 4'h0, 8'h00), 16'h0000, 1'b1);
		addRow(name, 40, longReq(8'h02, addr, 16'h0000), ramModel[addr], 1'b1);
	endtask

	task automatic buildTable();
		logic [31:0] randVal;
		logic [15:0] pairData;
		int          pairIdx;
		// Reset values
		addRegRead("getRegsAddr1", 4'd1);
		addRegRead("getRegsAddr2", 4'd2);
		addRegRead("getRegsAddr5", 4'd5);
		// One write sets both registers
		addRow("setRegs5A", 16, shortCmd(4'h2, 4'h0, 8'h5a), 16'h0000, 1'b1);
		reg0Model = 8'h5a;
		reg1Model = 8'h5a;
		addRegRead("getRegsAfterSet1", 4'd1);
		addRegRead("getRegsAfterSet2", 4'd2);
		addRow("sendId", 16, shortCmd(4'h6, 4'h0, 8'h00), 16'h7975, 1'b1);
		// Random write and read pairs
		for (pairIdx = 0; pairIdx < 4; pairIdx++) begin
			randVal = $random(seed);
			pairAddr[pairIdx] = randVal[9:0];
			randVal = $random(seed);
			pairData = randVal[15:0];
			ramModel[pairAddr[pairIdx]] = pairData;
			addRow($sformatf("ramWrite%0dHdr", pairIdx), 16, shortCmd(4'h9, 4'h0, 8'h00),
				16'h0000, 1'b1);
			addRow($sformatf("ramWrite%0d", pairIdx), 40,
				longReq(8'h01, pairAddr[pairIdx], pairData), 16'h0000, 1'b1);
			addRamRead($sformatf("ramRead%0d", pairIdx), pairAddr[pairIdx]);
		end
		// First address again, after the later writes
		addRamRead("ramReadBack0", pairAddr[0]);
		// Unknown codes leave nothing to shift out
		addRow("unknownCmd7", 16, shortCmd(4'h7, 4'h1, 8'hff), 16'h0000, 1'b1);
		addRow("unknownCmdA", 16, shortCmd(4'ha, 4'h2, 8'h55), 16'h0000, 1'b1);
		addRow("unknownCmdF", 16, shortCmd(4'hf, 4'hf, 8'haa), 16'h0000, 1'b1);
		addRow("badOpHdr", 16, shortCmd(4'h9, 4'h0, 8'h00), 16'h0000, 1'b1);
		addRow("badOp03", 40, longReq(8'h03, pairAddr[1], 16'hbeef), 16'h0000, 1'b1);
		addRow("sendIdAfterBad", 16, shortCmd(4'h6, 4'h0, 8'h00), 16'h7975, 1'b1);
	endtask

	// ------------------------------------------------
	// SPI host
	// ------------------------------------------------

	// Lands 1 ns past a rising edge
	task automatic waitClocks(input int count);
		repeat (count) @(posedge CLK);
		#1;
	endtask

	// Mode 0, MSB first, SCK at CLK/8
	task automatic spiFrame(input int width, input logic [39:0] word,
			output logic [15:0] captured);
		int bitIdx;
		captured = 16'h0000;
		waitClocks(1);
		CSEL = 1'b0;
		SCK  = 1'b0;
		MOSI = word[width-1];
		for (bitIdx = 0; bitIdx < width; bitIdx++) begin
			waitClocks(4);
			// MISO settled since the last falling edge
			if (bitIdx < 16) begin
				captured[15-bitIdx] = MISO;
			end
			SCK = 1'b1;
			waitClocks(4);
			SCK = 1'b0;
			if (bitIdx + 1 < width) begin
				MOSI = word[width-2-bitIdx];
			end
		end
		waitClocks(4);
		CSEL = 1'b1;
		MOSI = 1'b0;
		// Gap long enough for the reply load
		waitClocks(20);
	endtask

	// ------------------------------------------------
	// Checking
	// ------------------------------------------------

	task automatic checkRow(input int idx, input logic [15:0] actual);
		if (!rowCheck[idx]) begin
			$display("Sent %s, not checked", rowName[idx]);
		end else if (actual !== rowExpect[idx]) begin
			$display("Error %s expected %h actual %h", rowName[idx], rowExpect[idx], actual);
			errorCount = errorCount + 1;
		end else begin
			$display("Pass %s reply %h", rowName[idx], actual);
			passCount = passCount + 1;
		end
	endtask

	// ------------------------------------------------
	// Main sequence
	// ------------------------------------------------

	initial begin
		CMD_RST    = 1'b1;
		SCK        = 1'b0;
		MOSI       = 1'b0;
		CSEL       = 1'b1;
		errorCount = 0;
		passCount  = 0;
		numRows    = 0;
		reg0Model  = 8'h12;
		reg1Model  = 8'h34;
		seed       = 32'ha51b_134e;
		buildTable();
		timeoutLimit = numRows * 400 + 200;
		// Reset for 4 cycles
		repeat (4) @(posedge CLK);
		#1;
		CMD_RST = 1'b0;
		waitClocks(4);
		// Each frame carries the reply to the row before it
		for (rowIdx = 0; rowIdx < numRows; rowIdx++) begin
			spiFrame(rowWidth[rowIdx], rowWord[rowIdx], reply);
			if (rowIdx > 0) begin
				checkRow(rowIdx - 1, reply);
			end
		end
		// Command 0 frame to pull out the last reply
		spiFrame(16, shortCmd(4'h0, 4'h0, 8'h00), reply);
		checkRow(numRows - 1, reply);
		$display("Checks run %0d, passed %0d, failed %0d", passCount + errorCount, passCount,
			errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		cycleCount = 0;
		wait (timeoutLimit > 0);
		while (cycleCount < timeoutLimit) begin
			@(posedge CLK);
			cycleCount = cycleCount + 1;
		end
		$display("Timeout after %0d clock cycles, the frame sequence did not finish",
			cycleCount);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* logic/cmdDecoderTop.sv */
`timescale 1ns/1ns

module cmdDecoderTop #(
	parameter int RAM_ADDR_W = 10
) (
	input  logic CLK,
	input  logic CMD_RST,
	input  logic SCK,
	input  logic MOSI,
	input  logic CSEL,
	output logic MISO
);

	// SPI side
	logic                          txLoad;
	cmdPkg::cmdWord_u              txWord;
	logic                          longExpected;
	logic [cmdPkg::LONG_BITS-1:0]  rxWord;
	logic                          rxValid;
	logic                          busy;

	// Register and reply controls
	logic                          regWrite;
	logic [cmdPkg::VAL_W-1:0]      regVal;
	cmdPkg::replySel_e             replySel;
	logic [cmdPkg::ADDR_W-1:0]     replyAddr;

	// RAM buffer
	cmdPkg::ramCtl_t               ramCtl;
	logic [cmdPkg::SHORT_BITS-1:0] ramData;

	// ------------------------------------------------
	// SPI front end
	// ------------------------------------------------

	spiShifter i_spiShifter (
		.CLK          (CLK),
		.CMD_RST      (CMD_RST),
		.SCK          (SCK),
		.MOSI         (MOSI),
		.CSEL         (CSEL),
		.txLoad       (txLoad),
		.txWord       (txWord),
		.longExpected (longExpected),
		.MISO         (MISO),
		.rxWord       (rxWord),
		.rxValid      (rxValid),
		.busy         (busy)
	);

	// ------------------------------------------------
	// Command control and data
	// ------------------------------------------------

	cmdSequencer i_cmdSequencer (
		.CLK          (CLK),
		.CMD_RST      (CMD_RST),
		.rxWord       (rxWord),
		.rxValid      (rxValid),
		.busy         (busy),
		.ramData      (ramData),
		.txLoad       (txLoad),
		.longExpected (longExpected),
		.regWrite     (regWrite),
		.regVal       (regVal),
		.replySel     (replySel),
		.replyAddr    (replyAddr),
		.ramCtl       (ramCtl)
	);

	regBank i_regBank (
		.CLK       (CLK),
		.CMD_RST   (CMD_RST),
		.regWrite  (regWrite),
		.regVal    (regVal),
		.replySel  (replySel),
		.replyAddr (replyAddr),
		.ramData   (ramData),
		.txWord    (txWord)
	);

	// Depth set here
	ramBuffer #(
		.RAM_ADDR_W (RAM_ADDR_W)
	) i_ramBuffer (
		.CLK     (CLK),
		.ramCtl  (ramCtl),
		.ramData (ramData)
	);

endmodule

/* logic/cmdSequencer.sv */
`timescale 1ns/1ns

module cmdSequencer (
	input  logic                          CLK,
	input  logic                          CMD_RST,
	input  logic [cmdPkg::LONG_BITS-1:0]  rxWord,
	input  logic                          rxValid,
	input  logic                          busy,
	input  logic [cmdPkg::SHORT_BITS-1:0] ramData,
	output logic                          txLoad,
	output logic                          longExpected,
	output logic                          regWrite,
	output logic [cmdPkg::VAL_W-1:0]      regVal,
	output cmdPkg::replySel_e             replySel,
	output logic [cmdPkg::ADDR_W-1:0]     replyAddr,
	output cmdPkg::ramCtl_t               ramCtl
);

	typedef enum logic [2:0] {
		IDLE,
		DECODE,
		SET_REGS,
		LONG_WAIT,
		RAM_ACCESS,
		REPLY_WAIT
	} state_e;

	state_e state;
	state_e nextState;

	// Latched short frame
	cmdPkg::cmdWord_u cmdReg;

	// Long frame view of the receive register
	cmdPkg::ramReq_t ramReq;
	logic            reqWrite;
	logic            reqRead;

	// RAM request registers
	logic                                  ramWe;
	logic [cmdPkg::REQ_ADDR_W-1:0]         ramAddr;
	logic [cmdPkg::SHORT_BITS-1:0]         ramDin;

	assign ramReq   = rxWord;
	assign reqWrite = ramReq.op == cmdPkg::RAM_OP_WRITE;
	assign reqRead  = ramReq.op == cmdPkg::RAM_OP_READ;

	// ------------------------------------------------
	// FSM
	// ------------------------------------------------

	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (rxValid) begin
					nextState = DECODE;
				end
			end
			DECODE: begin
				case (cmdReg.fields.cmd)
					cmdPkg::setRegs: nextState = SET_REGS;
					cmdPkg::getRegs: nextState = REPLY_WAIT;
					cmdPkg::sendId:  nextState = REPLY_WAIT;
					cmdPkg::longMsg: nextState = LONG_WAIT;
					// Unknown codes, no reply
					default:         nextState = IDLE;
				endcase
			end
			SET_REGS: nextState = IDLE;
			LONG_WAIT: begin
				// Other op bytes are dropped
				if (rxValid) begin
					nextState = (reqWrite || reqRead) ? RAM_ACCESS : IDLE;
				end
			end
			// Writes end here, reads go on to reply
			RAM_ACCESS: nextState = ramWe ? IDLE : REPLY_WAIT;
			REPLY_WAIT: begin
				// Hold until the host raises CSEL
				if (!busy) begin
					nextState = IDLE;
				end
			end
			default: nextState = IDLE;
		endcase
	end

	// ------------------------------------------------
	// Frame latch and register controls
	// ------------------------------------------------

	// Only a fresh command is taken in IDLE
	always_ff @(posedge CLK) begin
		if (state == IDLE && rxValid) begin
			cmdReg.raw <= rxWord[cmdPkg::SHORT_BITS-1:0];
		end
	end

	assign regWrite     = state == SET_REGS;
	assign regVal       = cmdReg.fields.val;
	assign replyAddr    = cmdReg.fields.addr;
	assign longExpected = state == LONG_WAIT;

	// Reply source, settled before txLoad
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			replySel <= cmdPkg::replyRegs;
		end else if (state == DECODE && cmdReg.fields.cmd == cmdPkg::sendId) begin
			replySel <= cmdPkg::replyId;
		end else if (state == DECODE && cmdReg.fields.cmd == cmdPkg::getRegs) begin
			replySel <= cmdPkg::replyRegs;
		end else if (state == LONG_WAIT && rxValid && reqRead) begin
			replySel <= cmdPkg::replyRam;
		end
	end

	// Loads the shifter one cycle after CSEL is seen high
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			txLoad <= 1'b0;
		end else begin
			txLoad <= state == REPLY_WAIT && !busy;
		end
	end

	// ------------------------------------------------
	// RAM request
	// ------------------------------------------------

	// Write strobe is high for the RAM_ACCESS cycle only
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			ramWe <= 1'b0;
		end else begin
			ramWe <= state == LONG_WAIT && rxValid && reqWrite;
		end
	end

	always_ff @(posedge CLK) begin
		if (state == LONG_WAIT && rxValid) begin
			ramAddr <= ramReq.addr;
			ramDin  <= ramReq.data;
		end
	end

	assign ramCtl = '{we: ramWe, addr: ramAddr, din: ramDin};

endmodule

/* logic/ramBuffer.sv */
`timescale 1ns/1ns

module ramBuffer #(
	parameter int RAM_ADDR_W = 10
) (
	input  logic                          CLK,
	input  cmdPkg::ramCtl_t               ramCtl,
	output logic [cmdPkg::SHORT_BITS-1:0] ramData
);

	localparam int DEPTH = 2 ** RAM_ADDR_W;

	// Request registered one cycle ahead of the array
	cmdPkg::ramCtl_t       reqLatch;
	logic [RAM_ADDR_W-1:0] memAddr;

	logic [cmdPkg::SHORT_BITS-1:0] mem [DEPTH];

	// ------------------------------------------------
	// Request latch
	// ------------------------------------------------

	always_ff @(posedge CLK) begin
		reqLatch <= ramCtl;
	end

	// Upper request bits fall away on smaller buffers
	assign memAddr = reqLatch.addr[RAM_ADDR_W-1:0];

	// ------------------------------------------------
	// Single-port array
	// ------------------------------------------------

	// Read is registered, old data on a same-cycle write
	always_ff @(posedge CLK) begin
		if (reqLatch.we) begin
			mem[memAddr] <= reqLatch.din;
		end
		ramData <= mem[memAddr];
	end

endmodule

/* logic/regBank.sv */
`timescale 1ns/1ns

module regBank (
	input  logic                          CLK,
	input  logic                          CMD_RST,
	input  logic                          regWrite,
	input  logic [cmdPkg::VAL_W-1:0]      regVal,
	input  cmdPkg::replySel_e             replySel,
	input  logic [cmdPkg::ADDR_W-1:0]     replyAddr,
	input  logic [cmdPkg::SHORT_BITS-1:0] ramData,
	output cmdPkg::cmdWord_u              txWord
);

	// Test registers
	logic [cmdPkg::VAL_W-1:0] reg0;
	logic [cmdPkg::VAL_W-1:0] reg1;

	// Value byte of a register read
	logic [cmdPkg::VAL_W-1:0] regReadVal;

	// ------------------------------------------------
	// Registers
	// ------------------------------------------------

	// One write sets both
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			reg0 <= cmdPkg::REG0_RESET;
			reg1 <= cmdPkg::REG1_RESET;
		end else if (regWrite) begin
			reg0 <= regVal;
			reg1 <= regVal;
		end
	end

	// Address 1 is REG0, 2 is REG1, rest read 00
	always_comb begin
		case (replyAddr)
			4'd1:    regReadVal = reg0;
			4'd2:    regReadVal = reg1;
			default: regReadVal = '0;
		endcase
	end

	// ------------------------------------------------
	// Reply word
	// ------------------------------------------------

	always_comb begin
		case (replySel)
			cmdPkg::replyId:  txWord.raw = cmdPkg::DEVICE_ID;
			cmdPkg::replyRam: txWord.raw = ramData;
			default: begin
				// Echoes the getRegs header
				txWord.fields.cmd  = cmdPkg::getRegs;
				txWord.fields.addr = replyAddr;
				txWord.fields.val  = regReadVal;
			end
		endcase
	end

endmodule

/* spi/spiBitCounter.sv */
`timescale 1ns/1ns

module spiBitCounter (
	input  logic CLK,
	input  logic CMD_RST,
	input  logic sckRise,
	input  logic frameActive,
	input  logic longExpected,
	output logic frameDone
);

	// Enough for 40 bits
	logic [5:0] bitCount;
	logic [5:0] frameLen;
	logic       lastBit;

	// ------------------------------------------------
	// Frame length select
	// ------------------------------------------------

	// Long frame only after a longMsg command
	assign frameLen = longExpected ? 6'(cmdPkg::LONG_BITS) : 6'(cmdPkg::SHORT_BITS);

	// Edge that samples the final bit
	assign lastBit = frameActive && sckRise && (bitCount == frameLen - 6'd1);

	// ------------------------------------------------
	// Bit counter
	// ------------------------------------------------

	// Cleared between frames while CSEL is high
	always_ff @(posedge CLK) begin
		if (CMD_RST || !frameActive) begin
			bitCount <= '0;
		end else if (sckRise && (bitCount < frameLen)) begin
			// Stops at the length, extra edges dropped
			bitCount <= bitCount + 6'd1;
		end
	end

	// Single pulse per frame
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			frameDone <= 1'b0;
		end else begin
			frameDone <= lastBit;
		end
	end

endmodule

/* spi/spiShifter.sv */
`timescale 1ns/1ns

module spiShifter (
	input  logic                         CLK,
	input  logic                         CMD_RST,
	input  logic                         SCK,
	input  logic                         MOSI,
	input  logic                         CSEL,
	input  logic                         txLoad,
	input  cmdPkg::cmdWord_u             txWord,
	input  logic                         longExpected,
	output logic                         MISO,
	output logic [cmdPkg::LONG_BITS-1:0] rxWord,
	output logic                         rxValid,
	output logic                         busy
);

	// Third SCK stage holds the previous level
	logic [2:0] sckSync;
	logic [1:0] mosiSync;
	logic [1:0] cselSync;

	logic sckRise;
	logic sckFall;
	logic frameActive;
	logic frameDone;

	// Reply shift register, MSB drives MISO
	logic [cmdPkg::SHORT_BITS-1:0] txShift;

	// ------------------------------------------------
	// Pin synchronizers
	// ------------------------------------------------

	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			sckSync  <= '0;
			mosiSync <= '0;
			// CSEL idles high
			cselSync <= '1;
		end else begin
			sckSync  <= {sckSync[1:0], SCK};
			mosiSync <= {mosiSync[0], MOSI};
			cselSync <= {cselSync[0], CSEL};
		end
	end

	// Edge pulses, one CLK wide
	assign sckRise = sckSync[1] && !sckSync[2];
	assign sckFall = !sckSync[1] && sckSync[2];

	// CSEL low means a frame is on the wire
	assign frameActive = !cselSync[1];
	assign busy        = frameActive;

	// ------------------------------------------------
	// Receive path
	// ------------------------------------------------

	// Mode 0, sample on rising SCK
	always_ff @(posedge CLK) begin
		if (frameActive && sckRise) begin
			rxWord <= {rxWord[cmdPkg::LONG_BITS-2:0], mosiSync[1]};
		end
	end

	spiBitCounter i_spiBitCounter (
		.CLK          (CLK),
		.CMD_RST      (CMD_RST),
		.sckRise      (sckRise),
		.frameActive  (frameActive),
		.longExpected (longExpected),
		.frameDone    (frameDone)
	);

	// Last bit is in rxWord by now
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			rxValid <= 1'b0;
		end else begin
			rxValid <= frameDone;
		end
	end

	// ------------------------------------------------
	// Transmit path
	// ------------------------------------------------

	// Load only between frames; shift on falling SCK
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			txShift <= '0;
		end else if (txLoad) begin
			txShift <= txWord.raw;
		end else if (frameActive && sckFall) begin
			// Zeros fill in behind the reply
			txShift <= {txShift[cmdPkg::SHORT_BITS-2:0], 1'b0};
		end
	end

	// First bit valid before the first rising edge
	assign MISO = txShift[cmdPkg::SHORT_BITS-1];

endmodule

/* src.f */
common/cmdPkg.sv
spi/spiBitCounter.sv
spi/spiShifter.sv
logic/regBank.sv
logic/ramBuffer.sv
logic/cmdSequencer.sv
logic/cmdDecoderTop.sv
dv/cmdDecoderTb.sv
